// ==== dv/uart_tb_tasks.svh ====
// UART testbench tasks for comparing values, driving the receive line and capturing frames

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
endtask

// Start, data LSB first, even parity, stop; called on a falling clock edge
task automatic drive_rx_frame(input uart_byte_t data, input logic bad_parity,
                              input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, (^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
        rx_line = bits[i];
        repeat (clks_per_bit) @(negedge clk);
    end
    rx_line = 1'b1;
endtask

// Samples each bit near its middle, then times the tx_busy fall from the start edge
task automatic capture_tx_frame(output logic [10:0] bits);
    time t_edge;
    @(negedge tx_serial);
    t_edge = $time;
    repeat (half_bit) @(negedge clk);
    for (int i = 0; i < 11; i++) begin
        if (i > 0) begin
            repeat (clks_per_bit) @(negedge clk);
        end
        bits[i] = tx_serial;
        check_equal(tx_busy, 1'b1, "tx_busy high during frame");
    end
    @(negedge tx_busy);
    check_equal(32'($time - t_edge), 11 * clks_per_bit * clk_period, "tx_busy fall time");
    @(negedge clk);
endtask

// Counts falling clock edges from the start edge until rx_ready
task automatic expect_rx(input uart_byte_t data, input logic perr, input logic ferr);
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!rx_ready && n < rx_latency + clks_per_bit);
    check_equal(rx_ready, 1'b1, "rx_ready pulse seen");
    check_equal(n, rx_latency, "rx_ready latency");
    check_equal(rx_data, data, "rx_data");
    check_equal(rx_parity_error, perr, "rx_parity_error");
    check_equal(rx_frame_error, ferr, "rx_frame_error");
    @(negedge clk);
    check_equal(rx_ready, 1'b0, "rx_ready lasts one cycle");
endtask

// ==== dv/uart_tb.sv ====
// UART testbench with directed transmit, receive, error and loopback tests
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
    import uart_pkg::*;

    localparam int clk_period     = 20;
    localparam int rx_latency     = half_bit + 10 * clks_per_bit + 2;
    // 20 frames of 11 bits plus margin
    localparam int timeout_cycles = 20 * 11 * clks_per_bit + 480;

    logic       clk = 1'b0;
    logic       rst_n;
    uart_byte_t tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       tx_serial;
    logic       rx_line;
    logic       loopback;
    wire        rx_serial;
    uart_byte_t rx_data;
    logic       rx_ready;
    logic       rx_parity_error;
    logic       rx_frame_error;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    assign rx_serial = loopback ? tx_serial : rx_line;

    always #(clk_period / 2) clk = ~clk;

    uart_top uart_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .tx_data         (tx_data),
        .tx_start        (tx_start),
        .tx_busy         (tx_busy),
        .tx_serial       (tx_serial),
        .rx_serial       (rx_serial),
        .rx_data         (rx_data),
        .rx_ready        (rx_ready),
        .rx_parity_error (rx_parity_error),
        .rx_frame_error  (rx_frame_error)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    `include "uart_tb_tasks.svh"

    task automatic start_tx(input uart_byte_t data);
        tx_data  = data;
        tx_start = 1'b1;
        @(negedge clk);
        tx_start = 1'b0;
        check_equal(tx_busy, 1'b1, "tx_busy after accept");
    endtask

    task automatic check_tx_frame(input logic [10:0] bits, input uart_byte_t data);
        check_equal(bits[0], 1'b0, "tx start bit");
        check_equal(bits[8:1], data, "tx data bits");
        check_equal(bits[9], ^data, "tx parity bit");
        check_equal(bits[10], 1'b1, "tx stop bit");
    endtask

    task automatic test_reset_idle();
        check_equal(tx_serial, 1'b1, "tx_serial idle after reset");
        check_equal(tx_busy, 1'b0, "tx_busy after reset");
        check_equal(rx_ready, 1'b0, "rx_ready after reset");
        check_equal(rx_parity_error, 1'b0, "rx_parity_error after reset");
        check_equal(rx_frame_error, 1'b0, "rx_frame_error after reset");
    endtask

    task automatic test_tx_framing();
        logic [10:0] bits;
        uart_byte_t  data[4];
        data = '{8'h01, 8'ha5, uart_byte_t'($urandom_range(0, 255)),
                 uart_byte_t'($urandom_range(0, 255))};
        foreach (data[i]) begin
            start_tx(data[i]);
            capture_tx_frame(bits);
            check_tx_frame(bits, data[i]);
        end
    endtask

    task automatic test_tx_busy_guard();
        logic [10:0] bits;
        logic        stray;
        stray = 1'b0;
        start_tx(8'h3c);
        fork
            capture_tx_frame(bits);
            begin
                repeat (2 * clks_per_bit) @(negedge clk);
                tx_data  = 8'hc3;
                tx_start = 1'b1;
                @(negedge clk);
                tx_start = 1'b0;
            end
        join
        check_tx_frame(bits, 8'h3c);
        // A second accepted byte would start within one bit period
        repeat (2 * clks_per_bit) begin
            @(negedge clk);
            stray = stray | !tx_serial | tx_busy;
        end
        check_equal(stray, 1'b0, "no frame for tx_start while busy");
    endtask

    task automatic test_rx_good();
        uart_byte_t data[3];
        data = '{8'h5a, 8'h80, uart_byte_t'($urandom_range(0, 255))};
        foreach (data[i]) begin
            fork
                drive_rx_frame(data[i], 1'b0, 1'b0);
                expect_rx(data[i], 1'b0, 1'b0);
            join
        end
    endtask

    task automatic test_rx_errors();
        logic seen;
        seen = 1'b0;
        fork
            drive_rx_frame(8'h37, 1'b1, 1'b0);
            expect_rx(8'h37, 1'b1, 1'b0);
        join
        // Glitch shorter than half a bit
        rx_line = 1'b0;
        repeat (half_bit / 2) @(negedge clk);
        rx_line = 1'b1;
        repeat (rx_latency + clks_per_bit) begin
            @(negedge clk);
            seen = seen | rx_ready;
        end
        check_equal(seen, 1'b0, "no rx_ready after short low pulse");
        fork
            drive_rx_frame(8'hc4, 1'b0, 1'b1);
            expect_rx(8'hc4, 1'b0, 1'b1);
        join
        // Low stop bit starts a phantom frame that has to run out
        repeat (12 * clks_per_bit) @(negedge clk);
    endtask

    task automatic test_loopback();
        logic [10:0] bits;
        uart_byte_t  data;
        loopback = 1'b1;
        repeat (3) begin
            data = uart_byte_t'($urandom_range(0, 255));
            start_tx(data);
            fork
                capture_tx_frame(bits);
                begin
                    @(negedge tx_serial);
                    // Rising-edge start bit is seen as if driven at the next falling edge
                    @(negedge clk);
                    expect_rx(data, 1'b0, 1'b0);
                end
            join
            check_tx_frame(bits, data);
        end
        loopback = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h6717d30a));
        rst_n    = 1'b0;
        tx_data  = '0;
        tx_start = 1'b0;
        rx_line  = 1'b1;
        loopback = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_idle();
        test_tx_framing();
        test_tx_busy_guard();
        test_rx_good();
        test_rx_errors();
        test_loopback();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/baud_tick_gen.sv ====
// Baud divider giving a one-cycle tick at the start of every bit period
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int divisor = uart_pkg::clks_per_bit
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic baud_tick
);
    import uart_pkg::*;

    logic [div_cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            baud_tick <= 1'b0;
        end else if (cnt == div_cnt_w'(divisor - 1)) begin
            cnt       <= '0;
            baud_tick <= 1'b1;
        end else begin
            cnt       <= cnt + 1'b1;
            baud_tick <= 1'b0;
        end
    end

    a_tick_single: assert property (
        @(posedge clk) disable iff (!rst_n) baud_tick |=> !baud_tick
    );

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
// UART package with frame constants, the data byte type and the received bit roles
`default_nettype none

package uart_pkg;

    // Bit timing, short for simulation
    localparam int clks_per_bit = 16;
    localparam int half_bit     = 8;

    // Frame shape
    localparam int data_bits    = 8;

    // Counter widths
    localparam int bit_cnt_w    = 3;
    localparam int div_cnt_w    = 5;

    typedef logic [data_bits-1:0] uart_byte_t;

    // Role of a bit taken from the receive line
    typedef enum logic [1:0] {
        kind_data,
        kind_parity,
        kind_stop
    } bit_kind_t;

endpackage

`default_nettype wire

// ==== hw/uart_rx_frame.sv ====
// Receive frame checker, assembles the byte and flags parity and stop errors
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame (
    input  wire                  clk,
    input  wire                  rst_n,
    uart_sample_if.frame         smp,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_ready,
    output logic                 rx_parity_error,
    output logic                 rx_frame_error
);
    import uart_pkg::*;

    uart_byte_t shreg;
    logic       run_parity;
    logic       rx_parity_bit;
    logic       stop_seen;

    assign stop_seen = smp.sample_valid && (smp.sample_kind == kind_stop);

    // Data arrives LSB first, entering from the top
    always_ff @(posedge clk) begin
        if (smp.frame_start) begin
            run_parity <= 1'b0;
        end
        if (smp.sample_valid) begin
            case (smp.sample_kind)
                kind_data: begin
                    shreg      <= {smp.sample_bit, shreg[data_bits-1:1]};
                    run_parity <= run_parity ^ smp.sample_bit;
                end
                kind_parity: rx_parity_bit <= smp.sample_bit;
                default: ;
            endcase
        end
        if (stop_seen) begin
            rx_data <= shreg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_ready        <= 1'b0;
            rx_parity_error <= 1'b0;
            rx_frame_error  <= 1'b0;
        end else begin
            rx_ready <= stop_seen;
            if (stop_seen) begin
                rx_parity_error <= (rx_parity_bit != run_parity);
                rx_frame_error  <= !smp.sample_bit;
            end
        end
    end

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) rx_ready |=> !rx_ready
    );

endmodule

`default_nettype wire

// ==== hw/uart_rx_sampler.sv ====
// Receive line sampler, confirms the start bit and strobes each bit at mid-bit
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   rx_serial,
    uart_sample_if.sampler        smp
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } state_t;

    state_t               state;
    logic                 sync_1;
    logic                 rx_sync;
    logic [div_cnt_w-1:0] cnt;
    logic [bit_cnt_w-1:0] bit_cnt;
    logic                 bit_end;

    assign bit_end = (cnt == div_cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_1  <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            sync_1  <= rx_serial;
            rx_sync <= sync_1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= st_idle;
            cnt              <= '0;
            bit_cnt          <= '0;
            smp.sample_valid <= 1'b0;
            smp.frame_start  <= 1'b0;
        end else begin
            smp.sample_valid <= 1'b0;
            smp.frame_start  <= 1'b0;
            cnt              <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                st_idle: begin
                    // The synchronizer already holds two cycles of the start bit
                    cnt <= div_cnt_w'(2);
                    if (!rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (rx_sync) begin
                        state <= st_idle;
                    end else if (cnt == div_cnt_w'(half_bit - 1)) begin
                        smp.frame_start <= 1'b1;
                        cnt             <= '0;
                        bit_cnt         <= '0;
                        state           <= st_data;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        smp.sample_valid <= 1'b1;
                        bit_cnt          <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_cnt_w'(data_bits - 1)) begin
                            state <= st_parity;
                        end
                    end
                end
                st_parity: begin
                    if (bit_end) begin
                        smp.sample_valid <= 1'b1;
                        state            <= st_stop;
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        smp.sample_valid <= 1'b1;
                        state            <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bit_end) begin
            smp.sample_bit  <= rx_sync;
            smp.sample_kind <= (state == st_parity) ? kind_parity :
                               (state == st_stop)   ? kind_stop   : kind_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_sample_if.sv ====
// Sampled receive bits passed from the line sampler to the frame checker
`timescale 1ns/1ps
`default_nettype none

interface uart_sample_if;
    import uart_pkg::*;

    logic      sample_valid;
    logic      sample_bit;
    bit_kind_t sample_kind;
    logic      frame_start;

    modport sampler (
        output sample_valid, sample_bit, sample_kind, frame_start
    );

    modport frame (
        input sample_valid, sample_bit, sample_kind, frame_start
    );

endinterface

`default_nettype wire

// ==== hw/uart_top.sv ====
// UART top level with baud divider, transmitter and receiver
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  wire                  clk,
    input  wire                  rst_n,
    // Transmit side
    input  uart_pkg::uart_byte_t tx_data,
    input  wire                  tx_start,
    output logic                 tx_busy,
    output logic                 tx_serial,
    // Receive side
    input  wire                  rx_serial,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_ready,
    output logic                 rx_parity_error,
    output logic                 rx_frame_error
);

    logic baud_tick;

    uart_sample_if smp_if ();

    baud_tick_gen baud_tick_gen_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick)
    );

    uart_tx uart_tx_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_serial (tx_serial),
        .tx_busy   (tx_busy)
    );

    // Receiver keeps its own bit timer, independent of the transmit tick
    uart_rx_sampler uart_rx_sampler_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_serial (rx_serial),
        .smp       (smp_if.sampler)
    );

    uart_rx_frame uart_rx_frame_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .smp             (smp_if.frame),
        .rx_data         (rx_data),
        .rx_ready        (rx_ready),
        .rx_parity_error (rx_parity_error),
        .rx_frame_error  (rx_frame_error)
    );

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
// UART transmitter, frames a byte with start, even parity and stop bits
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 baud_tick,
    input  uart_pkg::uart_byte_t tx_data,
    input  wire                 tx_start,
    output logic                tx_serial,
    output logic                tx_busy
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } state_t;

    state_t               state;
    logic [bit_cnt_w-1:0] bit_cnt;
    uart_byte_t           shreg;
    logic                 parity_bit;
    logic                 accept;
    logic                 last_data;
    logic                 shift_en;

    assign accept    = tx_start && !tx_busy;
    assign last_data = (bit_cnt == bit_cnt_w'(data_bits - 1));
    // Each tick from start or data puts the next data bit on the line
    assign shift_en  = baud_tick &&
                       ((state == st_start) || (state == st_data && !last_data));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            bit_cnt   <= '0;
            tx_serial <= 1'b1;
            tx_busy   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        tx_busy <= 1'b1;
                    end else if (tx_busy && baud_tick) begin
                        tx_serial <= 1'b0;
                        state     <= st_start;
                    end
                end
                st_start: begin
                    if (baud_tick) begin
                        tx_serial <= shreg[0];
                        bit_cnt   <= '0;
                        state     <= st_data;
                    end
                end
                st_data: begin
                    if (baud_tick) begin
                        if (last_data) begin
                            tx_serial <= parity_bit;
                            state     <= st_parity;
                        end else begin
                            tx_serial <= shreg[0];
                            bit_cnt   <= bit_cnt + 1'b1;
                        end
                    end
                end
                st_parity: begin
                    if (baud_tick) begin
                        tx_serial <= 1'b1;
                        state     <= st_stop;
                    end
                end
                st_stop: begin
                    // Tick closing the stop bit frees the transmitter
                    if (baud_tick) begin
                        tx_busy <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Byte and its even parity, captured at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg      <= tx_data;
            parity_bit <= ^tx_data;
        end else if (shift_en) begin
            shreg <= {1'b0, shreg[data_bits-1:1]};
        end
    end

    a_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n) !tx_busy |-> tx_serial
    );

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
hw/uart_pkg.sv
hw/uart_sample_if.sv
hw/baud_tick_gen.sv
hw/uart_tx.sv
hw/uart_rx_sampler.sv
hw/uart_rx_frame.sv
hw/uart_top.sv
dv/uart_tb.sv
